// File: Makefile
TOOL  := verilator
FLAGS := --binary --timing --timescale 1ns/100ps -j 0
TOP   := tb_msx_bus
FLIST := compile.f
BUILD := obj_dir
LOG   := sim.log

SOURCES := $(wildcard source/*.sv tests/*.sv tests/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FLIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: compile.f
+incdir+tests
source/msx_bus_pkg.sv
source/cpu_bus_if.sv
source/slot_if.sv
source/slot_select.sv
source/mapper_regs.sv
source/memory_map.sv
source/msx_bus_top.sv
tests/tb_msx_bus.sv

// File: source/cpu_bus_if.sv
// Z80 style CPU bus as seen by the glue logic
// Strobes, address and write data, all driven from the top level
interface cpu_bus_if;

	logic                              mreq_n;	// Memory request
	logic                              iorq_n;	// I/O request
	logic                              rd_n;	// Read strobe
	logic                              wr_n;	// Write strobe
	logic [msx_bus_pkg::addr_w-1:0]    a;		// Address, I/O port in a[7:0]
	logic [msx_bus_pkg::data_w-1:0]    wdata;	// CPU write data

	// Bus owner side
	modport master (
		output mreq_n, iorq_n, rd_n, wr_n, a, wdata
	);

	// Register and decode blocks
	modport slave (
		input  mreq_n, iorq_n, rd_n, wr_n, a, wdata
	);

endinterface

// File: source/mapper_regs.sv
// Memory mapper segment registers
// Four registers at ports FCh to FFh, one per 16KB page. Outputs the
// segment of the page that the CPU addresses and reads back a register
module mapper_regs (
	input  logic                           clk42m,
	input  logic                           ff_reset_n,
	cpu_bus_if.slave                       bus,
	output logic [msx_bus_pkg::data_w-1:0] segment,
	output logic [msx_bus_pkg::data_w-1:0] q,
	output logic                           q_en
);
	logic [3:0][msx_bus_pkg::data_w-1:0] ff_segment;	// Indexed by page
	logic                                w_port_sel;
	logic                                w_io_wr;
	logic                                w_io_rd;

	// ------------------------------------------------------------------------
	// Port decode
	// ------------------------------------------------------------------------
	assign w_port_sel = (bus.a[7:2] == msx_bus_pkg::mapper_port_base[7:2]);
	assign w_io_wr    = !bus.iorq_n && !bus.wr_n && w_port_sel;
	assign w_io_rd    = !bus.iorq_n && !bus.rd_n && w_port_sel;

	// ------------------------------------------------------------------------
	// Segment registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_segment <= msx_bus_pkg::mapper_reset_seg;	// 3,2,1,0 like the BIOS
		end
		else if (w_io_wr) begin
			ff_segment[bus.a[1:0]] <= bus.wdata;
		end
	end

	// Segment of the addressed page, for the SDRAM address
	assign segment = ff_segment[bus.a[15:14]];

	// Readback during I/O read of FCh..FFh
	assign q    = w_io_rd ? ff_segment[bus.a[1:0]] : 8'hFF;
	assign q_en = w_io_rd;

endmodule

// File: source/memory_map.sv
// SDRAM memory map
// Turns slot, page and mapper segment into an SDRAM byte address and
// strobes, and registers the CPU read data from SDRAM or the slot and
// mapper readback
module memory_map (
	input  logic                                 clk42m,
	input  logic                                 ff_reset_n,
	cpu_bus_if.slave                             bus,
	slot_if.receiver                             slot,
	input  logic [msx_bus_pkg::data_w-1:0]       segment,
	input  logic [msx_bus_pkg::data_w-1:0]       map_q,
	input  logic                                 map_q_en,
	input  logic [msx_bus_pkg::data_w-1:0]       sdram_q,
	input  logic                                 sdram_q_en,
	output logic [msx_bus_pkg::sdram_addr_w-1:0] sdram_address,
	output logic                                 sdram_rd_n,
	output logic                                 sdram_wr_n,
	output logic [msx_bus_pkg::data_w-1:0]       rdata
);
	logic [1:0]                              w_page;
	logic                                    w_ram;		// Slot 3-0
	logic                                    w_main;	// Slot 0-0, pages 0-1
	logic                                    w_logo;	// Slot 0-3, pages 1-2
	logic                                    w_subrom;	// Slot 3-1, page 0
	logic                                    w_exp_reg;
	logic                                    w_mem_cycle;
	logic                                    w_hit;
	logic [msx_bus_pkg::sdram_addr_w-1:13]   w_upper;
	logic [msx_bus_pkg::data_w-1:0]          ff_rdata;

	// ------------------------------------------------------------------------
	// Region decode
	// ------------------------------------------------------------------------
	assign w_page   = bus.a[15:14];
	assign w_ram    = (slot.prim == msx_bus_pkg::slot_3) && (slot.sub == 2'd0);
	assign w_main   = (slot.prim == msx_bus_pkg::slot_0) && (slot.sub == 2'd0) && !bus.a[15];
	assign w_logo   = (slot.prim == msx_bus_pkg::slot_0) && (slot.sub == 2'd3) &&
	                  ((w_page == 2'd1) || (w_page == 2'd2));
	assign w_subrom = (slot.prim == msx_bus_pkg::slot_3) && (slot.sub == 2'd1) &&
	                  (w_page == 2'd0);

	// Secondary slot register sits over the SDRAM at FFFFh
	assign w_exp_reg = (bus.a == msx_bus_pkg::exp_slot_addr) &&
	                   ((slot.prim == msx_bus_pkg::slot_0) ||
	                    (slot.prim == msx_bus_pkg::slot_3));

	assign w_mem_cycle = !bus.mreq_n && bus.iorq_n && !w_exp_reg;
	assign w_hit       = w_ram || w_main || w_logo || w_subrom;

	// ------------------------------------------------------------------------
	// SDRAM address
	// ------------------------------------------------------------------------
	always_comb begin
		if (w_ram) begin
			w_upper = {msx_bus_pkg::region_ram_flag, segment, bus.a[13]};	// 8KB half of segment
		end
		else if (w_logo) begin
			w_upper = {msx_bus_pkg::region_logo_base, bus.a[14:13]};
		end
		else if (w_subrom) begin
			w_upper = {msx_bus_pkg::region_sub_base, bus.a[13]};
		end
		else if (w_main) begin
			w_upper = {msx_bus_pkg::region_main_base, bus.a[14:13]};
		end
		else begin
			w_upper = '0;		// Dropped regions, strobes stay idle
		end
	end

	assign sdram_address = {w_upper, bus.a[12:0]};

	// Plain strobes, no handshake
	assign sdram_rd_n = (w_mem_cycle && w_hit) ? bus.rd_n : 1'b1;
	assign sdram_wr_n = (w_mem_cycle && w_ram) ? bus.wr_n : 1'b1;	// Only RAM is writable

	// ------------------------------------------------------------------------
	// CPU read data
	// ------------------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_rdata <= 8'hFF;
		end
		else if (sdram_q_en) begin
			ff_rdata <= sdram_q;		// SDRAM wins, it arrives late
		end
		else if (slot.q_en) begin
			ff_rdata <= slot.q;
		end
		else if (map_q_en) begin
			ff_rdata <= map_q;
		end
		else if (bus.rd_n) begin
			ff_rdata <= 8'hFF;		// Idle bus reads as pull-up
		end
	end

	assign rdata = ff_rdata;

endmodule

// File: source/msx_bus_pkg.sv
// MSX bus glue shared definitions
// Bus widths, I/O port numbers, SDRAM region bases, mapper reset
// segments and the primary slot encoding
package msx_bus_pkg;

	// ------------------------------------------------------------------------
	// Bus widths
	// ------------------------------------------------------------------------
	localparam int addr_w       = 16;	// Z80 address bus
	localparam int data_w       = 8;	// Z80 data bus
	localparam int sdram_addr_w = 23;	// 8MB byte address space

	// ------------------------------------------------------------------------
	// Register locations
	// ------------------------------------------------------------------------
	localparam logic [7:0] io_ppi_port      = 8'hA8;	// A8h..ABh decoded as one
	localparam logic [7:0] mapper_port_base = 8'hFC;	// FCh..FFh, a[1:0] is the page

	// Secondary slot register, only inside an expanded slot
	localparam logic [addr_w-1:0] exp_slot_addr = 16'hFFFF;

	// Segments after reset, page 0 in the lowest byte
	localparam logic [3:0][data_w-1:0] mapper_reset_seg = {8'd0, 8'd1, 8'd2, 8'd3};

	// ------------------------------------------------------------------------
	// SDRAM regions, upper address bits [22:13]
	// ------------------------------------------------------------------------
	// MAIN-ROM 32KB at 020000h, a[14:13] appended
	localparam logic [7:0] region_main_base = 8'b0000_0100;
	// MSX logo and extended BASIC 32KB at 038000h, a[14:13] appended
	localparam logic [7:0] region_logo_base = 8'b0000_0111;
	// SUB-ROM 16KB at 040000h, a[13] appended
	localparam logic [8:0] region_sub_base  = 9'b0_0001_0000;
	// Mapper RAM in the upper 4MB, segment and a[13] appended
	localparam logic       region_ram_flag  = 1'b1;

	// ------------------------------------------------------------------------
	// Primary slot numbers
	// ------------------------------------------------------------------------
	typedef enum logic [1:0] {
		slot_0 = 2'd0,		// Expanded, BIOS side
		slot_1 = 2'd1,		// Cartridge
		slot_2 = 2'd2,		// Cartridge
		slot_3 = 2'd3		// Expanded, RAM side
	} slot_e;

endpackage

// File: source/msx_bus_top.sv
// MSX bus glue top level
// Binds the CPU and SDRAM side ports to the slot decoder, the mapper
// registers and the memory map
module msx_bus_top (
	input  logic                                 clk42m,
	input  logic                                 ff_reset_n,
	input  logic                                 mreq_n,
	input  logic                                 iorq_n,
	input  logic                                 rd_n,
	input  logic                                 wr_n,
	input  logic [msx_bus_pkg::addr_w-1:0]       a,
	input  logic [msx_bus_pkg::data_w-1:0]       wdata,
	input  logic [msx_bus_pkg::data_w-1:0]       sdram_q,
	input  logic                                 sdram_q_en,
	output logic [msx_bus_pkg::sdram_addr_w-1:0] sdram_address,
	output logic                                 sdram_rd_n,
	output logic                                 sdram_wr_n,
	output logic [msx_bus_pkg::data_w-1:0]       rdata
);
	logic [msx_bus_pkg::data_w-1:0] w_segment;
	logic [msx_bus_pkg::data_w-1:0] w_map_q;
	logic                           w_map_q_en;

	cpu_bus_if u_bus ();
	slot_if    u_slot ();

	// CPU bus into the interface
	assign u_bus.mreq_n = mreq_n;
	assign u_bus.iorq_n = iorq_n;
	assign u_bus.rd_n   = rd_n;
	assign u_bus.wr_n   = wr_n;
	assign u_bus.a      = a;
	assign u_bus.wdata  = wdata;

	// ------------------------------------------------------------------------
	// Slot and mapper registers side by side
	// ------------------------------------------------------------------------
	slot_select u_slot_select (
		.clk42m     (clk42m),
		.ff_reset_n (ff_reset_n),
		.bus        (u_bus),
		.slot       (u_slot)
	);

	mapper_regs u_mapper_regs (
		.clk42m     (clk42m),
		.ff_reset_n (ff_reset_n),
		.bus        (u_bus),
		.segment    (w_segment),
		.q          (w_map_q),
		.q_en       (w_map_q_en)
	);

	// Combines both into SDRAM access and read data
	memory_map u_memory_map (
		.clk42m        (clk42m),
		.ff_reset_n    (ff_reset_n),
		.bus           (u_bus),
		.slot          (u_slot),
		.segment       (w_segment),
		.map_q         (w_map_q),
		.map_q_en      (w_map_q_en),
		.sdram_q       (sdram_q),
		.sdram_q_en    (sdram_q_en),
		.sdram_address (sdram_address),
		.sdram_rd_n    (sdram_rd_n),
		.sdram_wr_n    (sdram_wr_n),
		.rdata         (rdata)
	);

endmodule

// File: source/slot_if.sv
// Decoded slot of the current access
// Also carries the slot register readback toward the read mux
interface slot_if;

	msx_bus_pkg::slot_e                prim;	// Primary slot of addressed page
	logic [1:0]                        sub;		// Secondary slot, 0 if not expanded
	logic [msx_bus_pkg::data_w-1:0]    q;		// Slot register readback
	logic                              q_en;	// Readback valid

	// Slot decoder side
	modport driver (
		output prim, sub, q, q_en
	);

	// Memory map side
	modport receiver (
		input  prim, sub, q, q_en
	);

endinterface

// File: source/slot_select.sv
// Slot selection
// Primary slot register at port A8h and the secondary slot registers of
// expanded slots 0 and 3 at FFFFh. Decodes the slot of the addressed page
// and supplies the register readback, secondary registers read inverted
module slot_select (
	input  logic     clk42m,
	input  logic     ff_reset_n,
	cpu_bus_if.slave bus,
	slot_if.driver   slot
);
	logic [7:0]    ff_prim_slot;		// Two bits per page
	logic [7:0]    ff_sub_slot [2];	// [0] slot 0, [1] slot 3
	logic [1:0]    w_page;
	logic          w_ppi_sel;
	logic          w_expanded;
	logic          w_exp_idx;
	logic          w_exp_reg;
	logic [7:0]    w_sub_reg;

	// ------------------------------------------------------------------------
	// Decode
	// ------------------------------------------------------------------------
	assign w_page    = bus.a[15:14];
	assign w_ppi_sel = (bus.a[7:2] == msx_bus_pkg::io_ppi_port[7:2]);

	assign slot.prim = msx_bus_pkg::slot_e'(ff_prim_slot[{w_page, 1'b0} +: 2]);

	// Only slots 0 and 3 carry a secondary register
	assign w_expanded = (slot.prim == msx_bus_pkg::slot_0) ||
	                    (slot.prim == msx_bus_pkg::slot_3);
	assign w_exp_idx  = slot.prim[1];		// Picks slot 0 or slot 3 register
	assign w_sub_reg  = ff_sub_slot[w_exp_idx];

	assign slot.sub  = w_expanded ? w_sub_reg[{w_page, 1'b0} +: 2] : 2'b00;

	// FFFFh only counts inside an expanded slot
	assign w_exp_reg = w_expanded && (bus.a == msx_bus_pkg::exp_slot_addr);

	// ------------------------------------------------------------------------
	// Primary slot register
	// ------------------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_prim_slot <= 8'h00;
		end
		else if (!bus.iorq_n && !bus.wr_n && w_ppi_sel) begin
			ff_prim_slot <= bus.wdata;		// Same value again is harmless
		end
	end

	// ------------------------------------------------------------------------
	// Secondary slot registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk42m) begin
		if (!ff_reset_n) begin
			ff_sub_slot[0] <= 8'h00;
			ff_sub_slot[1] <= 8'h00;
		end
		else if (!bus.mreq_n && !bus.wr_n && w_exp_reg) begin
			// Page 3 decides which expanded slot gets the write
			ff_sub_slot[w_exp_idx] <= bus.wdata;
		end
	end

	// ------------------------------------------------------------------------
	// Readback
	// ------------------------------------------------------------------------
	always_comb begin
		if (!bus.iorq_n && !bus.rd_n && w_ppi_sel) begin
			slot.q    = ff_prim_slot;
			slot.q_en = 1'b1;
		end
		else if (!bus.mreq_n && !bus.rd_n && w_exp_reg) begin
			slot.q    = ~w_sub_reg;		// Inverted, as on real hardware
			slot.q_en = 1'b1;
		end
		else begin
			slot.q    = 8'hFF;
			slot.q_en = 1'b0;
		end
	end

endmodule

// File: tests/tb_msx_bus_tests.svh
// Directed tests for the MSX bus glue
// Each task drives one behavior through the top-level ports and checks it

// Write FFFFh in the expanded slot that page 3 selects
task automatic write_sub_slot(input logic [7:0] data);
	logic [7:0]                           got;
	logic [msx_bus_pkg::sdram_addr_w-1:0] sa;
	logic                                 srd_n;
	logic                                 swr_n;
	mem_access(1'b1, msx_bus_pkg::exp_slot_addr, data, 1'b0, 8'h00, got, sa, srd_n, swr_n);
endtask

// Read that must reach the SDRAM at exp_addr
task automatic check_mapped_read(input logic [15:0] addr, input logic [22:0] exp_addr);
	logic [7:0]                           got;
	logic [msx_bus_pkg::sdram_addr_w-1:0] sa;
	logic                                 srd_n;
	logic                                 swr_n;
	mem_access(1'b0, addr, 8'h00, 1'b0, 8'h00, got, sa, srd_n, swr_n);
	if (sa !== exp_addr) report_mismatch("sdram_address", 32'(exp_addr), 32'(sa));
	if (srd_n !== 1'b0) report_mismatch("sdram_rd_n", 32'd0, 32'(srd_n));
	if (swr_n !== 1'b1) report_mismatch("sdram_wr_n", 32'd1, 32'(swr_n));
endtask

task automatic test_reset_values();
	int         errs;
	logic [7:0] got;
	errs = err_count;
	io_read(msx_bus_pkg::io_ppi_port, got);
	if (got !== 8'h00) report_mismatch("rdata", 32'h00, 32'(got));
	for (int p = 0; p < 4; p++) begin
		io_read(msx_bus_pkg::mapper_port_base + 8'(p), got);
		if (got !== 8'(3 - p)) report_mismatch("rdata", 32'(3 - p), 32'(got));	// 3,2,1,0
	end
	repeat (2) @(posedge clk42m);			// Idle bus with rd_n high
	@(negedge clk42m);
	if (rdata !== 8'hFF) report_mismatch("rdata", 32'hFF, 32'(rdata));
	end_test("reset values", errs);
endtask

task automatic test_primary_slot();
	int         errs;
	logic [7:0] data;
	logic [7:0] got;
	errs = err_count;
	data = 8'($urandom);
	io_write(msx_bus_pkg::io_ppi_port, data);
	io_read(msx_bus_pkg::io_ppi_port, got);
	if (got !== data) report_mismatch("rdata", 32'(data), 32'(got));
	end_test("primary slot register", errs);
endtask

task automatic test_secondary_slot();
	int                                   errs;
	logic [7:0]                           data;
	logic [7:0]                           inv;
	logic [7:0]                           got;
	logic [msx_bus_pkg::sdram_addr_w-1:0] sa;
	logic                                 srd_n;
	logic                                 swr_n;
	errs = err_count;
	for (int s = 3; s >= 0; s -= 3) begin	// Slot 3 then slot 0
		io_write(msx_bus_pkg::io_ppi_port, {2'(s), 6'b00_0000});
		data = {2'b00, 6'($urandom)};		// Page 3 keeps sub slot 0 so slot 3 has RAM under FFFFh
		inv  = ~data;
		write_sub_slot(data);
		mem_access(1'b0, msx_bus_pkg::exp_slot_addr, 8'h00, 1'b0, 8'h00, got, sa, srd_n, swr_n);
		if (got !== inv) report_mismatch("rdata", 32'(inv), 32'(got));
		if (srd_n !== 1'b1) report_mismatch("sdram_rd_n", 32'd1, 32'(srd_n));
	end
	end_test("secondary slot registers", errs);
endtask

task automatic test_rom_regions();
	int                                   errs;
	logic [15:0]                          addr;
	logic [7:0]                           got;
	logic [msx_bus_pkg::sdram_addr_w-1:0] sa;
	logic                                 srd_n;
	logic                                 swr_n;
	errs = err_count;
	// MAIN-ROM in slot 0-0
	io_write(msx_bus_pkg::io_ppi_port, 8'h00);
	write_sub_slot(8'h00);
	for (int p = 0; p < 2; p++) begin
		addr = {2'(p), 14'($urandom)};
		check_mapped_read(addr, {msx_bus_pkg::region_main_base, addr[14:13], addr[12:0]});
	end
	// Logo and extended BASIC in pages 1 and 2 of slot 0-3
	write_sub_slot(8'h3C);
	for (int p = 1; p < 3; p++) begin
		addr = {2'(p), 14'($urandom)};
		check_mapped_read(addr, {msx_bus_pkg::region_logo_base, addr[14:13], addr[12:0]});
	end
	// SUB-ROM in page 0 of slot 3-1
	io_write(msx_bus_pkg::io_ppi_port, 8'hC3);
	write_sub_slot(8'h01);
	addr = {2'b00, 14'($urandom)};
	check_mapped_read(addr, {msx_bus_pkg::region_sub_base, addr[13], addr[12:0]});
	// Cartridge slot 1 is not mapped
	io_write(msx_bus_pkg::io_ppi_port, 8'h01);
	addr = {2'b00, 14'($urandom)};
	mem_access(1'b0, addr, 8'h00, 1'b0, 8'h00, got, sa, srd_n, swr_n);
	if (srd_n !== 1'b1) report_mismatch("sdram_rd_n", 32'd1, 32'(srd_n));
	end_test("ROM regions", errs);
endtask

task automatic test_mapper_ram();
	int                                   errs;
	logic [7:0]                           seg;
	logic [15:0]                          addr;
	logic [22:0]                          exp_addr;
	logic [7:0]                           got;
	logic [msx_bus_pkg::sdram_addr_w-1:0] sa;
	logic                                 srd_n;
	logic                                 swr_n;
	errs = err_count;
	io_write(msx_bus_pkg::io_ppi_port, 8'hFF);	// All pages in slot 3
	write_sub_slot(8'h00);					// All pages in 3-0
	for (int p = 0; p < 4; p++) begin
		seg = 8'($urandom);
		io_write(msx_bus_pkg::mapper_port_base + 8'(p), seg);
		addr = {2'(p), 14'($urandom)};
		if (addr == msx_bus_pkg::exp_slot_addr) addr = 16'hFFFE;	// Skip slot register
		exp_addr = {msx_bus_pkg::region_ram_flag, seg, addr[13], addr[12:0]};
		check_mapped_read(addr, exp_addr);
		mem_access(1'b1, addr, 8'($urandom), 1'b0, 8'h00, got, sa, srd_n, swr_n);
		if (sa !== exp_addr) report_mismatch("sdram_address", 32'(exp_addr), 32'(sa));
		if (swr_n !== 1'b0) report_mismatch("sdram_wr_n", 32'd0, 32'(swr_n));
		if (srd_n !== 1'b1) report_mismatch("sdram_rd_n", 32'd1, 32'(srd_n));
	end
	end_test("mapper RAM", errs);
endtask

task automatic test_sdram_data();
	int                                   errs;
	logic [7:0]                           q;
	logic [7:0]                           got;
	logic [msx_bus_pkg::sdram_addr_w-1:0] sa;
	logic                                 srd_n;
	logic                                 swr_n;
	errs = err_count;
	q = 8'($urandom);
	mem_access(1'b0, {2'b00, 14'($urandom)}, 8'h00, 1'b1, q, got, sa, srd_n, swr_n);
	if (got !== q) report_mismatch("rdata", 32'(q), 32'(got));
	end_test("SDRAM read data", errs);
endtask

// File: tests/tb_msx_bus.sv
// MSX bus glue testbench
// Clock, reset, CPU bus cycle tasks, cycle limit and the closing summary
module tb_msx_bus;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int max_cycles = 3000;	// Tests need roughly 200 clocks

	logic                                 clk42m = 1'b0;
	logic                                 ff_reset_n;
	logic                                 mreq_n;
	logic                                 iorq_n;
	logic                                 rd_n;
	logic                                 wr_n;
	logic [msx_bus_pkg::addr_w-1:0]       a;
	logic [msx_bus_pkg::data_w-1:0]       wdata;
	logic [msx_bus_pkg::data_w-1:0]       sdram_q;
	logic                                 sdram_q_en;
	logic [msx_bus_pkg::sdram_addr_w-1:0] sdram_address;
	logic                                 sdram_rd_n;
	logic                                 sdram_wr_n;
	logic [msx_bus_pkg::data_w-1:0]       rdata;
	int                                   err_count   = 0;	// Mismatches over the run
	int                                   test_count  = 0;
	int                                   fail_tests  = 0;
	int                                   cycle_count = 0;

	msx_bus_top i_dut (
		.clk42m        (clk42m),
		.ff_reset_n    (ff_reset_n),
		.mreq_n        (mreq_n),
		.iorq_n        (iorq_n),
		.rd_n          (rd_n),
		.wr_n          (wr_n),
		.a             (a),
		.wdata         (wdata),
		.sdram_q       (sdram_q),
		.sdram_q_en    (sdram_q_en),
		.sdram_address (sdram_address),
		.sdram_rd_n    (sdram_rd_n),
		.sdram_wr_n    (sdram_wr_n),
		.rdata         (rdata)
	);

	always #50 clk42m = ~clk42m;		// 100 ns period

	// Cycle limit
	always @(posedge clk42m) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("Run stopped after %0d cycles, a test never finished", max_cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// CPU bus cycles
	// ------------------------------------------------------------------------
	task automatic io_write(input logic [7:0] port, input logic [7:0] data);
		@(posedge clk42m);
		iorq_n <= 1'b0;
		wr_n   <= 1'b0;
		a      <= {8'h00, port};
		wdata  <= data;
		@(posedge clk42m);			// Register loads here
		iorq_n <= 1'b1;
		wr_n   <= 1'b1;
	endtask

	task automatic io_read(input logic [7:0] port, output logic [7:0] data);
		@(posedge clk42m);
		iorq_n <= 1'b0;
		rd_n   <= 1'b0;
		a      <= {8'h00, port};
		@(posedge clk42m);			// Readback lands in rdata
		@(posedge clk42m);
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
		@(negedge clk42m);
		data = rdata;
	endtask

	// One memory cycle, SDRAM side captured mid cycle
	task automatic mem_access(
		input  logic                                 write,
		input  logic [msx_bus_pkg::addr_w-1:0]       addr,
		input  logic [7:0]                           data,
		input  logic                                 q_valid,	// Pulse sdram_q_en
		input  logic [7:0]                           q,
		output logic [7:0]                           read_data,
		output logic [msx_bus_pkg::sdram_addr_w-1:0] address,
		output logic                                 srd_n,
		output logic                                 swr_n
	);
		@(posedge clk42m);
		mreq_n     <= 1'b0;
		rd_n       <= write;
		wr_n       <= !write;
		a          <= addr;
		wdata      <= data;
		sdram_q    <= q;
		sdram_q_en <= q_valid;
		@(negedge clk42m);
		address = sdram_address;
		srd_n   = sdram_rd_n;
		swr_n   = sdram_wr_n;
		@(posedge clk42m);			// Write or SDRAM data takes effect
		sdram_q_en <= 1'b0;
		@(posedge clk42m);
		mreq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
		@(negedge clk42m);
		read_data = rdata;
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
	                               input logic [31:0] actual);
		$display("[FAIL] time %0t %s expected %0h got %0h", $time, name, expected, actual);
		err_count++;
	endtask

	task automatic end_test(input string name, input int errs_at_start);
		test_count++;
		if (err_count == errs_at_start) begin
			$display("%s: ok", name);
		end
		else begin
			fail_tests++;
			$display("%s: failed, %0d mismatches", name, err_count - errs_at_start);
		end
	endtask

	`include "tb_msx_bus_tests.svh"

	// ------------------------------------------------------------------------
	// Run
	// ------------------------------------------------------------------------
	initial begin
		ff_reset_n <= 1'b0;
		mreq_n     <= 1'b1;
		iorq_n     <= 1'b1;
		rd_n       <= 1'b1;
		wr_n       <= 1'b1;
		a          <= '0;
		wdata      <= '0;
		sdram_q    <= '0;
		sdram_q_en <= 1'b0;
		void'($urandom(32'h71d6_9495));
		repeat (16) @(posedge clk42m);
		ff_reset_n <= 1'b1;

		test_reset_values();
		test_primary_slot();
		test_secondary_slot();
		test_rom_regions();
		test_mapper_ram();
		test_sdram_data();

		$display("Tests run %0d, failed %0d, mismatches %0d", test_count, fail_tests, err_count);
		if (fail_tests == 0) begin
			$display("TEST PASS");
		end
		else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
